// ==== flist.f ====
+incdir+include
rtl/mcu_pkg.sv
rtl/mcu_spi.sv
rtl/mcu_protocol.sv
rtl/mcu_regs.sv
rtl/mem_bus_master.sv
rtl/mcu_top.sv
sim/mcu_properties.sv
sim/tb_mcu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_mcu_top
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100
PASS      = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== sim/tb_mcu_top.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module tb_mcu_top;

    import mcu_pkg::*;

    localparam int HALF    = 10;  // SPI half-period in clk cycles
    localparam int N_WORDS = 6;
    localparam int POLLS   = 20;

    logic        clk;
    logic        reset;
    logic        button;
    logic        mcu_clk;
    logic        mcu_cs;
    logic        mcu_mosi;
    logic        mcu_miso;
    logic        mem_request;
    logic        mem_write;
    logic [31:0] mem_bus_address;
    logic [15:0] mem_bus_wdata;
    logic        mem_ack;
    logic [15:0] mem_bus_rdata;
    logic [11:0] cfg_flags;

    integer      seed = 32'h3cf7;
    int          errors = 0;
    int          timeouts = 0;
    logic [7:0]  tx_q [$];
    logic [7:0]  rx_q [$];
    logic [15:0] mem_model [logic [31:0]];

    mcu_top i_mcu_top (
        .clk             (clk),
        .reset           (reset),
        .button          (button),
        .mcu_clk         (mcu_clk),
        .mcu_cs          (mcu_cs),
        .mcu_mosi        (mcu_mosi),
        .mcu_miso        (mcu_miso),
        .mem_request     (mem_request),
        .mem_write       (mem_write),
        .mem_bus_address (mem_bus_address),
        .mem_bus_wdata   (mem_bus_wdata),
        .mem_ack         (mem_ack),
        .mem_bus_rdata   (mem_bus_rdata),
        .cfg_flags       (cfg_flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SPI master in mode 0 with MSB first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic spi_transfer(input logic [7:0] data, output logic [7:0] reply);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi = data[i];
            repeat (HALF) @(negedge clk);
            reply[i] = mcu_miso;  // Sampled at the rising SPI edge
            mcu_clk  = 1'b1;
            repeat (HALF) @(negedge clk);
            mcu_clk  = 1'b0;
        end
    endtask

    task automatic run_frame();
        logic [7:0] reply;
        rx_q.delete();
        mcu_cs = 1'b0;
        repeat (HALF) @(negedge clk);
        for (int i = 0; i < tx_q.size(); i++) begin
            spi_transfer(tx_q[i], reply);
            rx_q.push_back(reply);
        end
        repeat (HALF) @(negedge clk);
        mcu_cs = 1'b1;
        repeat (HALF) @(negedge clk);
    endtask

    task automatic start_frame(input cmd_e cmd, input logic [7:0] addr);
        tx_q.delete();
        tx_q.push_back(cmd);
        tx_q.push_back(addr);
    endtask

    task automatic push_word(input logic [31:0] value);
        for (int i = 0; i < 4; i++) begin
            tx_q.push_back(value[8*i +: 8]);  // Least significant byte first
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] value);
        start_frame(CMD_REG_WRITE, addr);
        push_word(value);
        run_frame();
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] value);
        start_frame(CMD_REG_READ, addr);
        push_word(32'd0);
        run_frame();
        value = {rx_q[5], rx_q[4], rx_q[3], rx_q[2]};
    endtask

    // MEM_SCR control word with the start bit set
    function automatic logic [31:0] scr_word(input logic direction, input int count);
        scr_word = {17'd0, 10'(count), 2'b00, direction, 1'b0, 1'b1};
    endfunction

    task automatic wait_burst_done();
        logic [31:0] scr;
        int          tries;
        tries = 0;
        scr   = 32'h8;
        while (scr[3] !== 1'b0 && tries < POLLS) begin
            read_reg(REG_MEM_SCR, scr);
            tries++;
        end
        if (scr[3] !== 1'b0) begin
            timeouts++;
            $display("Timeout: memory burst still busy after %0d status reads", tries);
        end
    endtask

    function automatic logic [15:0] model_read(input logic [31:0] addr);
        if (mem_model.exists(addr)) begin
            model_read = mem_model[addr];
        end else begin
            model_read = addr[15:0] ^ addr[31:16] ^ 16'h5a5a;
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model with random ack latency
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : memory_model
        int delay;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (mem_request === 1'b1 && reset === 1'b0) begin
                delay = {$random(seed)} % 6;
                repeat (delay) @(negedge clk);
                if (mem_write) begin
                    mem_model[mem_bus_address] = mem_bus_wdata;
                end else begin
                    mem_bus_rdata = model_read(mem_bus_address);
                end
                mem_ack = 1'b1;
            end
        end
    end

    initial begin : main_sequence
        logic [31:0] value;
        logic [31:0] base;
        logic [31:0] addr;
        logic [15:0] words [N_WORDS];
        int          prop_fails;

        reset         = 1'b1;
        button        = 1'b0;  // Held low for the whole run
        mcu_clk       = 1'b0;
        mcu_cs        = 1'b1;
        mcu_mosi      = 1'b0;
        mem_ack       = 1'b0;
        mem_bus_rdata = 16'h0000;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        repeat (5) @(negedge clk);

        check_value("cfg_flags", 32'h001, 32'(cfg_flags));
        read_reg(REG_CFG_SCR, value);
        check_value("CFG_SCR", 32'h8000_0001, value);

        start_frame(CMD_IDENTIFY, 8'h00);
        run_frame();
        check_value("identify reply", 32'(`MCU_FPGA_ID), 32'(rx_q[1]));

        read_reg(REG_CFG_VERSION, value);
        check_value("CFG_VERSION", `MCU_CFG_VERSION, value);

        base = 32'h0001_2340;
        write_reg(REG_MEM_ADDRESS, base);
        read_reg(REG_MEM_ADDRESS, value);
        check_value("MEM_ADDRESS", base, value);

        // Second word goes to address 7 and must not touch the flags
        start_frame(CMD_REG_WRITE, REG_CFG_SCR);
        push_word(32'h0000_00a5);
        push_word(32'h0000_0fff);
        run_frame();
        check_value("cfg_flags", 32'h0a5, 32'(cfg_flags));
        read_reg(REG_CFG_SCR, value);
        check_value("CFG_SCR", 32'h8000_00a5, value);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Buffer to bus burst
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        start_frame(CMD_MEM_WRITE, 8'h00);
        for (int n = 0; n < N_WORDS; n++) begin
            words[n] = 16'($random(seed));
            tx_q.push_back(words[n][15:8]);
            tx_q.push_back(words[n][7:0]);
        end
        run_frame();
        write_reg(REG_MEM_SCR, scr_word(1'b1, N_WORDS));
        wait_burst_done();
        for (int n = 0; n < N_WORDS; n++) begin
            addr = base + 32'(2 * n);
            assert (mem_model.exists(addr)) else begin
                errors++;
                $display("No bus write reached address %h", addr);
            end
            if (mem_model.exists(addr)) begin
                check_value("mem_bus_wdata", 32'(words[n]), 32'(mem_model[addr]));
            end
        end

        // Bus to buffer burst and SPI readback
        base = 32'h0004_0800;
        for (int n = 0; n < N_WORDS; n++) begin
            words[n] = 16'($random(seed));
            mem_model[base + 32'(2 * n)] = words[n];
        end
        write_reg(REG_MEM_ADDRESS, base);
        write_reg(REG_MEM_SCR, scr_word(1'b0, N_WORDS));
        wait_burst_done();
        start_frame(CMD_MEM_READ, 8'h00);
        repeat (2 * N_WORDS) tx_q.push_back(8'h00);
        run_frame();
        for (int n = 0; n < N_WORDS; n++) begin
            check_value("mcu_miso word", 32'(words[n]), {16'd0, rx_q[2 + 2*n], rx_q[3 + 2*n]});
        end

        prop_fails = i_mcu_top.i_mcu_properties.fail_count;
        $display("Check errors: %0d, timeouts: %0d, property failures: %0d",
                 errors, timeouts, prop_fails);
        if (errors == 0 && timeouts == 0 && prop_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim/mcu_properties.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mcu_properties (
    input logic        clk,
    input logic        reset,
    input logic        mem_request,
    input logic        mem_ack,
    input logic [31:0] mem_bus_address,
    input logic [15:0] mem_bus_wdata,
    input logic [11:0] cfg_flags
);

    int unsigned fail_count = 0;

    // Reset values with the bootloader flag set
    reset_state: assert property (@(posedge clk)
        reset |=> (!mem_request && cfg_flags == 12'h001))
        else begin
            fail_count++;
            $error("mem_request or cfg_flags wrong after reset");
        end

    request_hold: assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=>
            (mem_request && $stable(mem_bus_address) && $stable(mem_bus_wdata)))
        else begin
            fail_count++;
            $error("mem_request dropped or bus changed before ack");
        end

    request_drop: assert property (@(posedge clk) disable iff (reset)
        (mem_request && mem_ack) |=> !mem_request)
        else begin
            fail_count++;
            $error("mem_request still high in the cycle after ack");
        end

    // Next word address
    address_step: assert property (@(posedge clk) disable iff (reset)
        (mem_request && mem_ack) |=>
            (mem_bus_address == $past(mem_bus_address) + `MCU_ADDR_STEP))
        else begin
            fail_count++;
            $error("mem_bus_address did not advance by one word");
        end

endmodule

bind mcu_top mcu_properties i_mcu_properties (
    .clk             (clk),
    .reset           (reset),
    .mem_request     (mem_request),
    .mem_ack         (mem_ack),
    .mem_bus_address (mem_bus_address),
    .mem_bus_wdata   (mem_bus_wdata),
    .cfg_flags       (cfg_flags)
);

// ==== rtl/mcu_top.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mcu_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        button,
    input  logic        mcu_clk,
    input  logic        mcu_cs,
    input  logic        mcu_mosi,
    output logic        mcu_miso,
    output logic        mem_request,
    output logic        mem_write,
    output logic [31:0] mem_bus_address,
    output logic [15:0] mem_bus_wdata,
    input  logic        mem_ack,
    input  logic [15:0] mem_bus_rdata,
    output logic [11:0] cfg_flags
);

    import mcu_pkg::*;

    logic                   frame_start;
    logic                   data_ready;
    logic [7:0]             rx_data;
    logic [7:0]             tx_data;
    logic                   reg_read;
    logic                   reg_write;
    reg_address_e           reg_address;
    reg_word_u              reg_wdata;
    logic [31:0]            reg_rdata;
    logic                   buf_read;
    logic                   buf_write;
    logic [`MCU_BUF_AW-1:0] buf_index;
    logic [15:0]            buf_wdata;
    logic [15:0]            buf_rdata;
    logic                   mem_start;
    logic                   mem_stop;
    logic                   mem_direction;
    logic [`MCU_BUF_AW-1:0] mem_length;
    logic [31:0]            mem_address;
    logic                   mem_busy;

    mcu_spi i_mcu_spi (
        .clk         (clk),
        .reset       (reset),
        .mcu_clk     (mcu_clk),
        .mcu_cs      (mcu_cs),
        .mcu_mosi    (mcu_mosi),
        .tx_data     (tx_data),
        .mcu_miso    (mcu_miso),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data)
    );

    mcu_protocol i_mcu_protocol (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .data_ready  (data_ready),
        .rx_data     (rx_data),
        .reg_rdata   (reg_rdata),
        .buf_rdata   (buf_rdata),
        .tx_data     (tx_data),
        .reg_read    (reg_read),
        .reg_write   (reg_write),
        .reg_address (reg_address),
        .reg_wdata   (reg_wdata),
        .buf_read    (buf_read),
        .buf_write   (buf_write),
        .buf_index   (buf_index),
        .buf_wdata   (buf_wdata)
    );

    mcu_regs i_mcu_regs (
        .clk           (clk),
        .reset         (reset),
        .button        (button),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .reg_address   (reg_address),
        .reg_wdata     (reg_wdata),
        .mem_busy      (mem_busy),
        .reg_rdata     (reg_rdata),
        .mem_start     (mem_start),
        .mem_stop      (mem_stop),
        .mem_direction (mem_direction),
        .mem_length    (mem_length),
        .mem_address   (mem_address),
        .cfg_flags     (cfg_flags)
    );

    mem_bus_master i_mem_bus_master (
        .clk             (clk),
        .reset           (reset),
        .buf_read        (buf_read),
        .buf_write       (buf_write),
        .buf_index       (buf_index),
        .buf_wdata       (buf_wdata),
        .mem_start       (mem_start),
        .mem_stop        (mem_stop),
        .mem_direction   (mem_direction),
        .mem_length      (mem_length),
        .mem_address     (mem_address),
        .mem_ack         (mem_ack),
        .mem_bus_rdata   (mem_bus_rdata),
        .buf_rdata       (buf_rdata),
        .mem_busy        (mem_busy),
        .mem_request     (mem_request),
        .mem_write       (mem_write),
        .mem_bus_address (mem_bus_address),
        .mem_bus_wdata   (mem_bus_wdata)
    );

endmodule

// ==== rtl/mem_bus_master.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mem_bus_master (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   buf_read,
    input  logic                   buf_write,
    input  logic [`MCU_BUF_AW-1:0] buf_index,
    input  logic [15:0]            buf_wdata,
    input  logic                   mem_start,
    input  logic                   mem_stop,
    input  logic                   mem_direction,
    input  logic [`MCU_BUF_AW-1:0] mem_length,
    input  logic [31:0]            mem_address,
    input  logic                   mem_ack,
    input  logic [15:0]            mem_bus_rdata,
    output logic [15:0]            buf_rdata,
    output logic                   mem_busy,
    output logic                   mem_request,
    output logic                   mem_write,
    output logic [31:0]            mem_bus_address,
    output logic [15:0]            mem_bus_wdata
);

    localparam logic [31:0] ADDR_STEP = `MCU_ADDR_STEP;

    logic [15:0]            buffer [0:`MCU_BUF_DEPTH-1];
    logic                   stop_pending;
    logic [`MCU_BUF_AW-1:0] word_count;
    logic                   last_word;

    assign last_word = (word_count == mem_length) || stop_pending;

    always_ff @(posedge clk) begin
        // SPI side port
        if (buf_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (buf_write) begin
            buffer[buf_index] <= buf_wdata;
        end

        if (reset) begin
            mem_busy     <= 1'b0;
            stop_pending <= 1'b0;
            mem_request  <= 1'b0;
            word_count   <= '0;
        end else begin
            if (mem_stop) begin
                stop_pending <= mem_busy;
            end else if (mem_start && !mem_busy) begin
                mem_write       <= mem_direction;
                mem_bus_address <= mem_address;
                mem_busy        <= 1'b1;
                word_count      <= '0;
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Burst side with one request per word
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (mem_busy) begin
                if (!mem_request) begin
                    mem_request   <= 1'b1;
                    mem_bus_wdata <= buffer[word_count];
                end

                if (mem_request && mem_ack) begin
                    mem_request     <= 1'b0;  // One idle cycle between words
                    mem_bus_address <= mem_bus_address + ADDR_STEP;
                    word_count      <= word_count + 1'b1;
                    if (!mem_write) begin
                        buffer[word_count] <= mem_bus_rdata;
                    end
                    if (last_word) begin
                        mem_busy     <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== rtl/mcu_regs.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mcu_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   button,
    input  logic                   reg_read,
    input  logic                   reg_write,
    input  mcu_pkg::reg_address_e  reg_address,
    input  mcu_pkg::reg_word_u     reg_wdata,
    input  logic                   mem_busy,
    output logic [31:0]            reg_rdata,
    output logic                   mem_start,
    output logic                   mem_stop,
    output logic                   mem_direction,
    output logic [`MCU_BUF_AW-1:0] mem_length,
    output logic [31:0]            mem_address,
    output logic [11:0]            cfg_flags
);

    import mcu_pkg::*;

    localparam int STAGES = `MCU_SYNC_STAGES;
    localparam int LEN_W  = `MCU_BUF_AW;

    logic [STAGES-1:0] button_ff;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[STAGES-2:0], button};

        if (reg_read) begin
            case (reg_address)
                REG_MEM_ADDRESS: reg_rdata <= mem_address;
                REG_MEM_SCR:     reg_rdata <= {28'd0, mem_busy, 3'b000};
                REG_CFG_SCR:     reg_rdata <= {~button_ff[STAGES-1], 19'd0, cfg_flags};
                REG_CFG_VERSION: reg_rdata <= `MCU_CFG_VERSION;
                default:         reg_rdata <= 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        mem_start <= 1'b0;
        mem_stop  <= 1'b0;

        if (reset) begin
            cfg_flags <= 12'h001;  // Bootloader on
        end else if (reg_write) begin
            case (reg_address)
                REG_MEM_ADDRESS: begin
                    mem_address <= reg_wdata;
                end
                REG_MEM_SCR: begin
                    mem_start     <= reg_wdata.scr.start;
                    mem_stop      <= reg_wdata.scr.stop;
                    mem_direction <= reg_wdata.scr.direction;
                    mem_length    <= LEN_W'(reg_wdata.scr.count - 10'd1);
                end
                REG_CFG_SCR: begin
                    cfg_flags <= {reg_wdata.bytes[1][3:0], reg_wdata.bytes[0]};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== rtl/mcu_protocol.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mcu_protocol (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   frame_start,
    input  logic                   data_ready,
    input  logic [7:0]             rx_data,
    input  logic [31:0]            reg_rdata,
    input  logic [15:0]            buf_rdata,
    output logic [7:0]             tx_data,
    output logic                   reg_read,
    output logic                   reg_write,
    output mcu_pkg::reg_address_e  reg_address,
    output mcu_pkg::reg_word_u     reg_wdata,
    output logic                   buf_read,
    output logic                   buf_write,
    output logic [`MCU_BUF_AW-1:0] buf_index,
    output logic [15:0]            buf_wdata
);

    import mcu_pkg::*;

    phase_e    phase;
    cmd_e      cmd;
    logic [1:0] counter;
    logic [7:0] address;
    logic       word_select;
    reg_word_u  rdata_word;

    assign reg_address = reg_address_e'(address);
    assign buf_index   = {address, word_select};
    assign rdata_word  = reg_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        reg_read  <= 1'b0;
        reg_write <= 1'b0;
        buf_read  <= 1'b0;
        buf_write <= 1'b0;

        if (reset) begin
            phase       <= PHASE_NOP;
            cmd         <= CMD_IDENTIFY;
            counter     <= 2'd0;
            address     <= 8'd0;
            word_select <= 1'b0;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase   <= PHASE_CMD;
            end

            // Step after each register word or full buffer word pair
            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= cmd_e'(rx_data);
                        if (rx_data > CMD_MEM_WRITE) begin
                            phase <= PHASE_NOP;  // Unknown command
                        end else begin
                            phase <= PHASE_ADDRESS;
                        end
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase   <= PHASE_DATA;
                        if (cmd == CMD_REG_READ) begin
                            reg_read <= 1'b1;
                        end
                        if (cmd == CMD_MEM_READ) begin
                            buf_read    <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        case (cmd)
                            CMD_REG_READ: begin
                                reg_read <= (counter == 2'd3);
                            end
                            CMD_REG_WRITE: begin
                                reg_wdata.bytes[counter] <= rx_data;
                                reg_write <= (counter == 2'd3);
                            end
                            CMD_MEM_READ: begin
                                if (counter[0]) begin
                                    buf_read    <= 1'b1;
                                    word_select <= !word_select;
                                end
                            end
                            CMD_MEM_WRITE: begin
                                if (!counter[0]) begin
                                    buf_wdata[15:8] <= rx_data;  // High byte first
                                end else begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write      <= 1'b1;
                                    word_select    <= counter[1];
                                end
                            end
                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    // Reply for the next byte on the wire
    always_comb begin
        case (cmd)
            CMD_IDENTIFY: tx_data = `MCU_FPGA_ID;
            CMD_REG_READ: tx_data = rdata_word.bytes[counter];
            CMD_MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            default:      tx_data = 8'h00;
        endcase
    end

endmodule

// ==== rtl/mcu_spi.sv ====
`timescale 1ns/1ps
`include "mcu_defines.svh"

module mcu_spi (
    input  logic       clk,
    input  logic       reset,
    input  logic       mcu_clk,
    input  logic       mcu_cs,
    input  logic       mcu_mosi,
    input  logic [7:0] tx_data,
    output logic       mcu_miso,
    output logic       frame_start,
    output logic       data_ready,
    output logic [7:0] rx_data
);

    localparam int STAGES = `MCU_SYNC_STAGES;

    logic [STAGES-1:0] clk_ff;
    logic [STAGES-1:0] cs_ff;
    logic [STAGES-1:0] mosi_ff;
    logic              clk_prev;
    logic              cs_prev;
    logic              clk_rise;
    logic              clk_fall;
    logic [2:0]        bit_count;
    logic [6:0]        rx_shift;
    logic [7:0]        tx_shift;
    logic [1:0]        load_pipe;

    always_ff @(posedge clk) begin
        clk_ff  <= {clk_ff[STAGES-2:0], mcu_clk};
        cs_ff   <= {cs_ff[STAGES-2:0], mcu_cs};
        mosi_ff <= {mosi_ff[STAGES-2:0], mcu_mosi};
    end

    // Edges only count while selected
    assign clk_rise = !clk_prev && clk_ff[STAGES-1] && !cs_ff[STAGES-1];
    assign clk_fall = clk_prev && !clk_ff[STAGES-1] && !cs_ff[STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_prev    <= 1'b0;
            cs_prev     <= 1'b1;
            frame_start <= 1'b0;
            data_ready  <= 1'b0;
            bit_count   <= 3'd0;
            load_pipe   <= 2'b00;
        end else begin
            clk_prev    <= clk_ff[STAGES-1];
            cs_prev     <= cs_ff[STAGES-1];
            frame_start <= cs_prev && !cs_ff[STAGES-1];  // Falling chip select
            data_ready  <= 1'b0;
            load_pipe   <= {load_pipe[0], frame_start || data_ready};

            if (frame_start) begin
                bit_count <= 3'd0;
            end else if (clk_rise) begin
                bit_count <= bit_count + 3'd1;
                rx_shift  <= {rx_shift[5:0], mosi_ff[STAGES-1]};
                if (bit_count == 3'd7) begin
                    data_ready <= 1'b1;
                    rx_data    <= {rx_shift, mosi_ff[STAGES-1]};
                end
            end
        end
    end

    // No shift on the falling edge that closes a byte
    always_ff @(posedge clk) begin
        if (load_pipe[1]) begin
            tx_shift <= tx_data;
        end else if (clk_fall && (bit_count != 3'd0)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign mcu_miso = tx_shift[7];  // MSB first

endmodule

// ==== rtl/mcu_pkg.sv ====
package mcu_pkg;

    // Frame command byte
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR     = 8'd1,
        REG_CFG_SCR     = 8'd6,
        REG_CFG_VERSION = 8'd10
    } reg_address_e;

    // Register word as seen on the wire or as MEM_SCR control
    typedef union packed {
        logic [3:0][7:0] bytes;          // bytes[0] is least significant
        struct packed {
            logic [16:0] reserved_hi;
            logic [9:0]  count;          // 1 to 512 words
            logic [1:0]  reserved_lo;
            logic        direction;      // 1 = buffer to bus
            logic        stop;
            logic        start;
        } scr;
    } reg_word_u;

endpackage

// ==== include/mcu_defines.svh ====
`ifndef MCU_DEFINES_SVH
`define MCU_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Identification
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MCU_FPGA_ID      8'h64          // IDENTIFY reply byte
`define MCU_CFG_VERSION  32'h5343_7632  // CFG_VERSION read value

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Staging buffer and memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define MCU_BUF_DEPTH    512  // Words of 16 bits
`define MCU_BUF_AW       9
`define MCU_ADDR_STEP    2    // Bytes per bus word

`define MCU_SYNC_STAGES  3    // Flops per async input

`endif
